/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = decode_tb
FILELIST = decode_stage.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, output goes to $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG) && ! grep -q "RESULT: FAIL" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* common/mcpu_pkg.sv */
package mcpu_pkg;

  localparam int xlen       = 32;
  localparam int reg_num_w  = 5;
  localparam int opcode_w   = 9;
  localparam int num_preds  = 3;  // predicate 3 is hardwired true
  localparam int pred_num_w = 2;

  localparam int shift_type_w = 2;
  localparam int shift_amt_w  = 6;
  localparam int lsu_off_w    = 12;

  // which execute unit takes the operation
  typedef enum logic [1:0] {
    oper_alu    = 2'd0,
    oper_lsu    = 2'd1,
    oper_branch = 2'd2,
    oper_other  = 2'd3
  } oper_t;

  // coprocessor sub-ops, carried in execute_opcode[8:5]
  typedef enum logic [3:0] {
    coproc_break   = 4'd0,
    coproc_syscall = 4'd1,
    coproc_fence   = 4'd2,
    coproc_eret    = 4'd3,
    coproc_flush   = 4'd4,
    coproc_mfc     = 4'd5,
    coproc_mtc     = 4'd6,
    coproc_mult    = 4'd7,
    coproc_div     = 4'd8,
    coproc_mfhi    = 4'd9,
    coproc_mthi    = 4'd10
  } coproc_op_t;

  // alu sub-op that writes a predicate rather than a register
  localparam logic [3:0] alu_compare = 4'b0111;

  // short immediate shift type, rotate
  localparam logic [1:0] shift_rotate = 2'b11;

  // branch link register
  localparam logic [reg_num_w-1:0] link_reg = 5'd31;

endpackage

/* decode/dep_scoreboard.sv */
`timescale 1ns/1ps

module dep_scoreboard import mcpu_pkg::*; #(
  parameter int num_regs = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue,
  input  logic [reg_num_w-1:0]   rd_num,
  input  logic                   rd_we,
  input  logic                   pred_we,
  input  logic                   wb_en,
  input  logic [reg_num_w-1:0]   wb_num,
  input  logic                   wb_pred_en,
  input  logic [pred_num_w-1:0]  wb_pred_num,
  output logic [num_regs-1:0]    reg_busy,
  output logic [num_preds-1:0]   pred_busy
);

  logic [pred_num_w-1:0] pred_dst;

  assign pred_dst = rd_num[pred_num_w-1:0];  // compares name the predicate in rd

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_busy  <= '0;
      pred_busy <= '0;
    end else begin
      // clear first so a same-cycle issue keeps the bit set
      if (wb_en) begin
        reg_busy[wb_num] <= 1'b0;
      end
      if (issue && rd_we) begin
        reg_busy[rd_num] <= 1'b1;
      end

      if (wb_pred_en && wb_pred_num < num_preds) begin
        pred_busy[wb_pred_num] <= 1'b0;
      end
      if (issue && pred_we && pred_dst < num_preds) begin
        pred_busy[pred_dst] <= 1'b1;  // p3 never goes busy
      end
    end
  end

endmodule

/* decode/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import mcpu_pkg::*; (
  input  logic [xlen-1:0]             inst,
  input  logic [xlen-1:0]             next_inst,
  input  logic [num_preds-1:0]        preds,
  input  logic                        prev_long_imm,
  input  logic [(1<<reg_num_w)-1:0]   reg_busy,
  input  logic [num_preds-1:0]        pred_busy,
  input  logic [xlen-1:0]             rs_data,
  input  logic [xlen-1:0]             rt_data,
  output logic [reg_num_w-1:0]        rs_num,
  output logic [reg_num_w-1:0]        rt_num,
  output logic [opcode_w-1:0]         execute_opcode,
  output logic [shift_type_w-1:0]     shift_type,
  output logic [shift_amt_w-1:0]      shift_amount,
  output oper_t                       oper_type,
  output logic [reg_num_w-1:0]        rd_num,
  output logic                        rd_we,
  output logic                        pred_we,
  output logic [xlen-1:0]             sop,
  output logic [lsu_off_w-1:0]        lsu_offset,
  output logic                        long_imm,
  output logic                        invalid,
  output logic                        branch_reg,
  output logic                        dep_stall
);

  logic                 depend_rs;
  logic                 depend_rt;
  logic [num_preds:0]   all_preds;
  logic [num_preds:0]   all_pred_busy;
  logic [pred_num_w-1:0] guard;
  logic                 guard_busy;

  // execute units pick the bits they need and flag bad sub-ops themselves
  assign execute_opcode = {inst[23:19], inst[13:10]};

  assign rs_num = inst[4:0];
  assign rt_num = inst[18:14];
  assign guard  = inst[31:30];

  assign all_preds     = {1'b1, preds};
  assign all_pred_busy = {1'b0, pred_busy};

  // stores split the offset around the rt field
  assign lsu_offset = execute_opcode[2] ? {inst[24:19], inst[13], inst[9:5]} : inst[24:13];

  assign guard_busy = all_pred_busy[guard] & ~prev_long_imm;  // data words have no guard

  assign dep_stall = (depend_rs & reg_busy[rs_num]) |
                     (depend_rt & reg_busy[rt_num]) |
                     guard_busy |
                     (rd_we & reg_busy[rd_num]) |
                     (pred_we & all_pred_busy[rd_num[pred_num_w-1:0]]);

  always_comb begin
    rd_num       = inst[9:5];
    rd_we        = 1'b0;
    pred_we      = 1'b0;
    oper_type    = oper_alu;
    shift_type   = '0;
    shift_amount = '0;
    sop          = '0;
    long_imm     = 1'b0;
    invalid      = 1'b0;
    branch_reg   = 1'b0;
    depend_rs    = 1'b0;
    depend_rt    = 1'b0;

    if ((all_preds[guard] ^ inst[29]) && !prev_long_imm) begin
      if (!inst[28]) begin  // alu short immediate
        pred_we      = execute_opcode[3:0] == alu_compare;
        rd_we        = !pred_we;
        shift_type   = shift_rotate;
        shift_amount = {1'b0, inst[17:14], 1'b0};
        sop[9:0]     = inst[27:18];
        if (execute_opcode[3]) begin
          sop[14:10] = inst[4:0];  // one operand form, rs field is more immediate
        end else begin
          depend_rs = 1'b1;
        end
      end else if (inst[27:26] == 2'b01) begin  // alu register
        sop          = rt_data;
        pred_we      = execute_opcode[3:0] == alu_compare;
        rd_we        = !pred_we;
        shift_type   = inst[20:19];
        shift_amount = {1'b0, inst[25:21]};
        depend_rt    = 1'b1;
        depend_rs    = !execute_opcode[3];
      end else if (inst[27:25] == 3'b001) begin  // load/store
        oper_type = oper_lsu;
        sop       = rt_data;
        rd_we     = !execute_opcode[2];
        depend_rs = 1'b1;
        depend_rt = execute_opcode[2];
        if (execute_opcode[2:0] == 3'b111) begin
          pred_we = 1'b1;
          rd_num  = '0;
        end
      end else if (inst[27]) begin  // branch
        oper_type  = oper_branch;
        rd_num     = link_reg;
        rd_we      = inst[25];  // link
        branch_reg = inst[26];
        if (inst[26]) begin
          depend_rs = 1'b1;
          sop       = {{12{inst[24]}}, inst[24:5]};
        end else begin
          sop = {{7{inst[24]}}, inst[24:0]};
        end
      end else if (inst[24]) begin  // coprocessor
        oper_type = oper_other;
        sop       = rt_data;
        case (coproc_op_t'(execute_opcode[8:5]))
          coproc_break, coproc_syscall, coproc_fence, coproc_eret: ;
          coproc_flush, coproc_mtc, coproc_mthi: depend_rs = 1'b1;
          coproc_mfc, coproc_mfhi: rd_we = 1'b1;
          coproc_mult, coproc_div: begin
            depend_rs = 1'b1;
            depend_rt = 1'b1;
            rd_we     = 1'b1;
          end
          default: invalid = 1'b1;
        endcase
      end else if (|inst[23:22]) begin
        invalid = 1'b1;
      end else if (inst[21]) begin  // register shift
        depend_rs  = 1'b1;
        depend_rt  = 1'b1;
        rd_we      = 1'b1;
        sop        = rt_data;
        shift_type = inst[20:19];
        // anything past 31 saturates to one flag bit
        shift_amount = {|rs_data[31:5], rs_data[4:0]};
      end else if (|inst[20:14]) begin
        invalid = 1'b1;
      end else begin  // alu long immediate
        sop       = next_inst;
        long_imm  = 1'b1;
        depend_rs = !execute_opcode[3];
        pred_we   = execute_opcode[3:0] == alu_compare;
        rd_we     = !pred_we;
      end
    end
  end

endmodule

/* decode_stage.f */
common/mcpu_pkg.sv
source/reg_file.sv
decode/dep_scoreboard.sv
decode/inst_decode.sv
source/decode_stage.sv
verif/decode_props.sv
verif/decode_checker.sv
verif/decode_tb.sv

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import mcpu_pkg::*; #(
  parameter int num_regs = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [xlen-1:0]         inst,
  input  logic [xlen-1:0]         next_inst,
  input  logic                    inst_valid,
  input  logic                    wb_en,
  input  logic [reg_num_w-1:0]    wb_num,
  input  logic [xlen-1:0]         wb_data,
  input  logic                    wb_pred_en,
  input  logic [pred_num_w-1:0]   wb_pred_num,
  input  logic                    wb_pred_val,
  output logic                    stall,
  output logic                    out_valid,
  output logic [opcode_w-1:0]     out_execute_opcode,
  output logic [shift_type_w-1:0] out_shift_type,
  output logic [shift_amt_w-1:0]  out_shift_amount,
  output oper_t                   out_oper_type,
  output logic [reg_num_w-1:0]    out_rd_num,
  output logic                    out_rd_we,
  output logic                    out_pred_we,
  output logic [xlen-1:0]         out_sop,
  output logic [lsu_off_w-1:0]    out_lsu_offset,
  output logic                    out_invalid,
  output logic                    out_branch_reg
);

  localparam int regs_max = 1 << reg_num_w;

  logic [reg_num_w-1:0]    rs_num, rt_num, rd_num;
  logic [xlen-1:0]         rs_data, rt_data, sop;
  logic [num_preds-1:0]    preds, pred_busy;
  logic [num_regs-1:0]     reg_busy;
  logic [regs_max-1:0]     reg_busy_all;
  logic [opcode_w-1:0]     execute_opcode;
  logic [shift_type_w-1:0] shift_type;
  logic [shift_amt_w-1:0]  shift_amount;
  logic [lsu_off_w-1:0]    lsu_offset;
  oper_t                   oper_type;
  logic                    rd_we, pred_we, long_imm, invalid, branch_reg, dep_stall;
  logic                    prev_long_imm;
  logic                    issue;

  assign reg_busy_all = regs_max'(reg_busy);  // a smaller file leaves the top bits idle
  assign stall = inst_valid & dep_stall;
  assign issue = inst_valid & ~stall;

  inst_decode u_decode (.*, .reg_busy(reg_busy_all));

  dep_scoreboard #(.num_regs(num_regs)) u_scoreboard (.*);

  reg_file #(.num_regs(num_regs)) u_reg_file (.*);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid     <= 1'b0;
      prev_long_imm <= 1'b0;
    end else begin
      out_valid <= issue;
      if (issue) begin
        prev_long_imm <= long_imm;  // data word decodes with long_imm low
      end
    end
  end

  // issue register, qualified by out_valid
  always_ff @(posedge clk) begin
    if (issue) begin
      out_execute_opcode <= execute_opcode;
      out_shift_type     <= shift_type;
      out_shift_amount   <= shift_amount;
      out_oper_type      <= oper_type;
      out_rd_num         <= rd_num;
      out_rd_we          <= rd_we;
      out_pred_we        <= pred_we;
      out_sop            <= sop;
      out_lsu_offset     <= lsu_offset;
      out_invalid        <= invalid;
      out_branch_reg     <= branch_reg;
    end
  end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file import mcpu_pkg::*; #(
  parameter int num_regs = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [reg_num_w-1:0]   rs_num,
  input  logic [reg_num_w-1:0]   rt_num,
  input  logic                   wb_en,
  input  logic [reg_num_w-1:0]   wb_num,
  input  logic [xlen-1:0]        wb_data,
  input  logic                   wb_pred_en,
  input  logic [pred_num_w-1:0]  wb_pred_num,
  input  logic                   wb_pred_val,
  output logic [xlen-1:0]        rs_data,
  output logic [xlen-1:0]        rt_data,
  output logic [num_preds-1:0]   preds
);

  logic [xlen-1:0] regs [num_regs];

  // no bypass, decode stalls on anything still in flight
  assign rs_data = regs[rs_num];
  assign rt_data = regs[rt_num];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_num] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      preds <= '0;
    end else if (wb_pred_en && wb_pred_num < num_preds) begin
      preds[wb_pred_num] <= wb_pred_val;  // writes to p3 are dropped
    end
  end

endmodule

/* verif/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker import mcpu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [xlen-1:0]         inst,
  input  logic [xlen-1:0]         next_inst,
  input  logic                    inst_valid,
  input  logic                    wb_en,
  input  logic [reg_num_w-1:0]    wb_num,
  input  logic [xlen-1:0]         wb_data,
  input  logic                    wb_pred_en,
  input  logic [pred_num_w-1:0]   wb_pred_num,
  input  logic                    wb_pred_val,
  input  logic                    stall,
  input  logic                    out_valid,
  input  logic [opcode_w-1:0]     out_execute_opcode,
  input  logic [shift_type_w-1:0] out_shift_type,
  input  logic [shift_amt_w-1:0]  out_shift_amount,
  input  oper_t                   out_oper_type,
  input  logic [reg_num_w-1:0]    out_rd_num,
  input  logic                    out_rd_we,
  input  logic                    out_pred_we,
  input  logic [xlen-1:0]         out_sop,
  input  logic [lsu_off_w-1:0]    out_lsu_offset,
  input  logic                    out_invalid,
  input  logic                    out_branch_reg,
  output int                      errors,
  output int                      checks
);

  typedef struct packed {
    logic [opcode_w-1:0]     opcode;
    logic [shift_type_w-1:0] shift_type;
    logic [shift_amt_w-1:0]  shift_amount;
    oper_t                   oper;
    logic [reg_num_w-1:0]    rd_num;
    logic [xlen-1:0]         sop;
    logic [lsu_off_w-1:0]    lsu_offset;
    logic                    rd_we, pred_we, invalid, branch_reg, long_imm, dep_rs, dep_rt;
  } dec_t;

  logic [xlen-1:0]      sh_regs [32];
  logic [num_preds-1:0] sh_preds, busy_pred;
  logic [31:0]          busy_reg;
  logic                 pending, long_prev;
  dec_t                 d, exp_dec;

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got %0h expected %0h", name, got, exp);
    end
  endtask

  function automatic dec_t predict_decode(input logic [xlen-1:0] w, input logic [xlen-1:0] nw,
                                          input logic after_long);
    dec_t r;
    logic guard_val, cmp;
    r = '0;
    r.opcode     = {w[23:19], w[13:10]};
    r.rd_num     = w[9:5];
    r.lsu_offset = w[12] ? {w[24:19], w[13], w[9:5]} : w[24:13];  // store splits the offset
    r.oper       = oper_alu;
    guard_val    = (w[31:30] == 2'd3) ? 1'b1 : sh_preds[w[31:30]];
    cmp          = w[13:10] == alu_compare;
    if (after_long || guard_val == w[29]) begin
      return r;  // data word or false guard
    end
    if (!w[28]) begin
      r.pred_we      = cmp;
      r.rd_we        = !cmp;
      r.shift_type   = 2'b11;
      r.shift_amount = {1'b0, w[17:14], 1'b0};
      r.sop          = w[13] ? {17'd0, w[4:0], w[27:18]} : {22'd0, w[27:18]};
      r.dep_rs       = !w[13];
    end else if (w[27:26] == 2'b01) begin
      r.sop          = sh_regs[w[18:14]];
      r.pred_we      = cmp;
      r.rd_we        = !cmp;
      r.shift_type   = w[20:19];
      r.shift_amount = {1'b0, w[25:21]};
      r.dep_rt       = 1'b1;
      r.dep_rs       = !w[13];
    end else if (w[27:25] == 3'b001) begin
      r.oper   = oper_lsu;
      r.sop    = sh_regs[w[18:14]];
      r.dep_rs = 1'b1;
      r.dep_rt = w[12];  // stores read rt
      r.rd_we  = !w[12];
      if (w[12:10] == 3'b111) begin
        r.pred_we = 1'b1;
        r.rd_num  = '0;
      end
    end else if (w[27]) begin
      r.oper       = oper_branch;
      r.rd_num     = 5'd31;
      r.rd_we      = w[25];
      r.branch_reg = w[26];
      r.dep_rs     = w[26];
      r.sop        = w[26] ? {{12{w[24]}}, w[24:5]} : {{7{w[24]}}, w[24:0]};
    end else if (w[24]) begin
      r.oper = oper_other;
      r.sop  = sh_regs[w[18:14]];
      case (w[23:20])
        coproc_break, coproc_syscall, coproc_fence, coproc_eret: ;
        coproc_flush, coproc_mtc, coproc_mthi: r.dep_rs = 1'b1;
        coproc_mfc, coproc_mfhi: r.rd_we = 1'b1;
        coproc_mult, coproc_div: begin
          r.dep_rs = 1'b1;
          r.dep_rt = 1'b1;
          r.rd_we  = 1'b1;
        end
        default: r.invalid = 1'b1;
      endcase
    end else if (w[23:22] != 2'b00 || (!w[21] && w[20:14] != 7'd0)) begin
      r.invalid = 1'b1;  // reserved bits set
    end else if (w[21]) begin
      r.dep_rs       = 1'b1;
      r.dep_rt       = 1'b1;
      r.rd_we        = 1'b1;
      r.sop          = sh_regs[w[18:14]];
      r.shift_type   = w[20:19];
      r.shift_amount = {(sh_regs[w[4:0]] > 32'd31), sh_regs[w[4:0]][4:0]};
    end else begin
      r.sop      = nw;
      r.long_imm = 1'b1;
      r.dep_rs   = !w[13];
      r.pred_we  = cmp;
      r.rd_we    = !cmp;
    end
    return r;
  endfunction

  function automatic logic stall_expected(input dec_t r, input logic [xlen-1:0] w,
                                          input logic after_long);
    logic [num_preds:0] pbusy;
    pbusy = {1'b0, busy_pred};  // p3 is never busy
    return (r.dep_rs && busy_reg[w[4:0]]) || (r.dep_rt && busy_reg[w[18:14]]) ||
           (!after_long && pbusy[w[31:30]]) || (r.rd_we && busy_reg[r.rd_num]) ||
           (r.pred_we && pbusy[r.rd_num[1:0]]);
  endfunction

  task automatic compare_issue();
    check_field("out_execute_opcode", 32'(out_execute_opcode), 32'(exp_dec.opcode));
    check_field("out_shift_type", 32'(out_shift_type), 32'(exp_dec.shift_type));
    check_field("out_shift_amount", 32'(out_shift_amount), 32'(exp_dec.shift_amount));
    check_field("out_oper_type", 32'(out_oper_type), 32'(exp_dec.oper));
    check_field("out_rd_num", 32'(out_rd_num), 32'(exp_dec.rd_num));
    check_field("out_rd_we", 32'(out_rd_we), 32'(exp_dec.rd_we));
    check_field("out_pred_we", 32'(out_pred_we), 32'(exp_dec.pred_we));
    check_field("out_sop", out_sop, exp_dec.sop);
    check_field("out_lsu_offset", 32'(out_lsu_offset), 32'(exp_dec.lsu_offset));
    check_field("out_invalid", 32'(out_invalid), 32'(exp_dec.invalid));
    check_field("out_branch_reg", 32'(out_branch_reg), 32'(exp_dec.branch_reg));
  endtask

  always @(posedge clk) begin
    if (rst) begin
      sh_regs   = '{default: '0};
      sh_preds  = '0;
      busy_reg  = '0;
      busy_pred = '0;
      pending   = 1'b0;
      long_prev = 1'b0;
      errors    = 0;
      checks    = 0;
    end else begin
      if (pending && out_valid !== 1'b1) begin
        errors++;
        $display("no issue output in the cycle after an accepted instruction");
      end else if (pending) begin
        compare_issue();
      end else if (out_valid !== 1'b0) begin
        errors++;
        $display("out_valid high without an accepted instruction");
      end

      d = predict_decode(inst, next_inst, long_prev);
      check_field("stall", 32'(stall), 32'(inst_valid && stall_expected(d, inst, long_prev)));
      pending = inst_valid && !stall;
      if (pending) begin
        exp_dec   = d;
        long_prev = d.long_imm;
      end

      // writeback clears before issue sets
      if (wb_en) begin
        sh_regs[wb_num]  = wb_data;
        busy_reg[wb_num] = 1'b0;
      end
      if (wb_pred_en && wb_pred_num != 2'd3) begin
        sh_preds[wb_pred_num]  = wb_pred_val;
        busy_pred[wb_pred_num] = 1'b0;
      end
      if (pending && d.rd_we) begin
        busy_reg[d.rd_num] = 1'b1;
      end
      if (pending && d.pred_we && d.rd_num[1:0] != 2'd3) begin
        busy_pred[d.rd_num[1:0]] = 1'b1;
      end
    end
  end

endmodule

/* verif/decode_props.sv */
`timescale 1ns/1ps

module decode_props (
  input logic clk,
  input logic rst,
  input logic inst_valid,
  input logic stall,
  input logic out_valid
);

  logic accepted;
  int   fail_count = 0;

  assign accepted = inst_valid && !stall;

  a_valid_after_accept: assert property (@(posedge clk) disable iff (rst)
    accepted |=> out_valid)
    else begin
      fail_count++;
      $error("out_valid missing in the cycle after an accepted instruction");
    end

  a_no_valid_when_idle: assert property (@(posedge clk) disable iff (rst)
    !accepted |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high without an accepted instruction");
    end

  a_no_rise_on_stall: assert property (@(posedge clk) disable iff (rst)
    $rose(out_valid) |-> !$past(stall))
    else begin
      fail_count++;
      $error("out_valid rose after a stalled cycle");
    end

  a_stall_low_after_reset: assert property (@(posedge clk)
    rst |=> !stall)
    else begin
      fail_count++;
      $error("stall high right after reset");
    end

endmodule

/* verif/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb import mcpu_pkg::*; ();

  localparam int cycle_ns    = 100;
  localparam int num_insts   = 400;
  localparam int watchdog_ns = (num_insts * 20 + 16) * cycle_ns;

  logic                    clk, rst, inst_valid, stall, out_valid;
  logic [xlen-1:0]         inst, next_inst;
  logic                    wb_en = 1'b0;
  logic [reg_num_w-1:0]    wb_num = '0;
  logic [xlen-1:0]         wb_data = '0;
  logic                    wb_pred_en = 1'b0;
  logic [pred_num_w-1:0]   wb_pred_num = '0;
  logic                    wb_pred_val = 1'b0;
  logic [opcode_w-1:0]     out_execute_opcode;
  logic [shift_type_w-1:0] out_shift_type;
  logic [shift_amt_w-1:0]  out_shift_amount;
  oper_t                   out_oper_type;
  logic [reg_num_w-1:0]    out_rd_num;
  logic                    out_rd_we, out_pred_we, out_invalid, out_branch_reg;
  logic [xlen-1:0]         out_sop;
  logic [lsu_off_w-1:0]    out_lsu_offset;
  int                      errors, checks;

  logic [31:0]           lfsr;
  logic [reg_num_w-1:0]  reg_q [$];
  logic [pred_num_w-1:0] pred_q [$];
  logic [xlen-1:0]       cur_word, nxt_word, wb_rand;
  logic                  do_reg, do_pred;

  decode_stage #(.num_regs(32)) dut (.*);

  decode_checker u_checker (.*);

  bind decode_stage decode_props u_props (.*);

  // taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [xlen-1:0] make_word();
    logic [xlen-1:0] w;
    logic [2:0]      fmt;
    w   = take_bits(xlen);
    fmt = 3'(take_bits(3));
    if (take_bits(2) == 0) begin
      w[13:10] = alu_compare;
    end
    case (fmt)
      3'd0: w[28] = 1'b0;
      3'd1: w[28:26] = 3'b101;
      3'd2: w[28:25] = 4'b1001;
      3'd3: w[28:27] = 2'b11;
      3'd4: w[28:24] = 5'b10001;
      3'd5: w[28:21] = 8'b1000_0001;  // register shift
      3'd6: w[28:14] = 15'b100_0000_0000_0000;  // long immediate
      default: ;
    endcase
    if (fmt >= 3'd5 && fmt != 3'd7 && take_bits(2) == 0) begin
      w[fmt == 3'd5 ? 22 : 16] = 1'b1;  // reserved bit
    end
    return w;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(cycle_ns / 2) clk = ~clk;
  end

  // retire busy destinations after a random delay
  always @(posedge clk) begin
    if (out_valid === 1'b1 && out_rd_we) begin
      reg_q.push_back(out_rd_num);
    end
    if (out_valid === 1'b1 && out_pred_we) begin
      pred_q.push_back(out_rd_num[pred_num_w-1:0]);
    end
    do_reg  = take_bits(1) == 1;
    do_pred = take_bits(1) == 1;
    wb_rand = take_bits(xlen);
    #1;
    wb_en      = do_reg && reg_q.size() > 0;
    wb_pred_en = do_pred && pred_q.size() > 0;
    if (wb_en) begin
      wb_num  = reg_q.pop_front();
      wb_data = wb_rand;
    end
    if (wb_pred_en) begin
      wb_pred_num = pred_q.pop_front();
      wb_pred_val = wb_rand[0];
    end
  end

  initial begin
    lfsr       = 32'h05e6_6f5f;
    rst        = 1'b1;
    inst       = '0;
    next_inst  = '0;
    inst_valid = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst      = 1'b0;
    cur_word = make_word();
    nxt_word = make_word();
    for (int i = 0; i < num_insts; i++) begin
      inst       = cur_word;
      next_inst  = nxt_word;  // data word of a long immediate comes next
      inst_valid = 1'b1;
      @(posedge clk);
      while (stall) @(posedge clk);
      #1;
      cur_word = nxt_word;
      nxt_word = make_word();
      if (take_bits(3) == 0) begin
        inst_valid = 1'b0;
        @(posedge clk);
        #1;
      end
    end
    inst_valid = 1'b0;
    repeat (4) @(posedge clk);
    $display("checks %0d errors %0d assertion failures %0d", checks, errors,
             dut.u_props.fail_count);
    if (errors == 0 && dut.u_props.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: instructions not all issued within %0d ns", watchdog_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
